//--- design/renamePkg.sv
`default_nettype none

package renamePkg;

    // Architectural registers, r0 reads as zero and is never renamed
    localparam int NUM_ARCH = 8;

    // Physical register tags
    localparam int NUM_TAGS = 16;

    typedef logic [$clog2(NUM_ARCH)-1:0] ArchReg;
    typedef logic [$clog2(NUM_TAGS)-1:0] Tag;

    // Wraps around, order is taken from the signed difference
    typedef logic [5:0] SqN;

    typedef struct packed {
        logic       valid;
        ArchReg     rs0;
        ArchReg     rs1;
        ArchReg     rd;
        logic [7:0] imm;
    } DecUop;

    typedef struct packed {
        logic       valid;
        SqN         sqN;
        Tag         tagA;
        Tag         tagB;
        logic       availA;
        logic       availB;
        Tag         tagDst;
        logic       hasDst;
        ArchReg     rd;
        logic [7:0] imm;
    } RenUop;

    typedef struct packed {
        logic   valid;
        ArchReg rd;
        Tag     tagDst;
        SqN     sqN;
    } ComUop;

    typedef struct packed {
        logic valid;
        Tag   tag;
    } WbResult;

endpackage

`default_nettype wire

//--- design/renameTable.sv
`default_nettype none
`timescale 1ns/10ps

module renameTable import renamePkg::*; #(
    parameter int WIDTH = 2
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 flush,
    input  wire ArchReg         lookupIds [2*WIDTH],
    output Tag                  lookupTags [2*WIDTH],
    output logic [2*WIDTH-1:0]  lookupAvail,
    input  wire [WIDTH-1:0]     issueValid,
    input  wire ArchReg         issueIds [WIDTH],
    input  wire Tag             issueTags [WIDTH],
    input  wire ComUop          comUop [WIDTH],
    output Tag                  commitPrevTags [WIDTH],
    output logic [WIDTH-1:0]    commitPrevValid,
    input  wire WbResult        wbRes [WIDTH]
);

    Tag                  specMap [NUM_ARCH];
    Tag                  comMap [NUM_ARCH];
    Tag                  comMapNext [NUM_ARCH];
    logic [NUM_TAGS-1:0] ready;

    // Lookups see the map from before this cycle's issue writes
    always_comb begin
        for (int i = 0; i < 2*WIDTH; i++) begin
            lookupTags[i] = specMap[lookupIds[i]];
            lookupAvail[i] = ready[lookupTags[i]];
            // Writeback in the same cycle counts as ready
            for (int k = 0; k < WIDTH; k++) begin
                if (wbRes[k].valid && wbRes[k].tag == lookupTags[i])
                    lookupAvail[i] = 1'b1;
            end
        end
    end

    // Tag released by each commit
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            commitPrevValid[i] = comUop[i].valid && comUop[i].rd != '0;
            commitPrevTags[i] = comMap[comUop[i].rd];
            // A younger commit to the same register retires this op's own tag
            for (int j = i + 1; j < WIDTH; j++) begin
                if (comUop[j].valid && comUop[j].rd == comUop[i].rd)
                    commitPrevTags[i] = comUop[i].tagDst;
            end
        end
    end

    always_comb begin
        comMapNext = comMap;
        for (int i = 0; i < WIDTH; i++) begin
            if (commitPrevValid[i])
                comMapNext[comUop[i].rd] = comUop[i].tagDst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, every tag holds a value
            for (int r = 0; r < NUM_ARCH; r++) begin
                specMap[r] <= Tag'(r);
                comMap[r] <= Tag'(r);
            end
            ready <= '1;
        end else begin
            comMap <= comMapNext;
            if (flush) begin
                // Committed values are all written back
                specMap <= comMapNext;
                ready <= '1;
            end else begin
                for (int k = 0; k < WIDTH; k++) begin
                    if (wbRes[k].valid)
                        ready[wbRes[k].tag] <= 1'b1;
                end
                // Slot order, last writer wins
                for (int i = 0; i < WIDTH; i++) begin
                    if (issueValid[i]) begin
                        specMap[issueIds[i]] <= issueTags[i];
                        ready[issueTags[i]] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/tagFreeList.sv
`default_nettype none
`timescale 1ns/10ps

module tagFreeList import renamePkg::*; #(
    parameter int WIDTH = 2
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              flush,
    input  wire [WIDTH-1:0]  allocReq,
    output Tag               allocTags [WIDTH],
    output logic             enough,
    input  wire              allocTake,
    input  wire [WIDTH-1:0]  freeValid,
    input  wire Tag          freeTags [WIDTH],
    input  wire ComUop       comUop [WIDTH]
);

    logic [NUM_TAGS-1:0] freeVec;
    logic [NUM_TAGS-1:0] freeNext;
    logic [NUM_TAGS-1:0] comOwned;
    logic [NUM_TAGS-1:0] comOwnedNext;

    // Lowest free tags go to requesting slots in order
    always_comb begin
        logic [NUM_TAGS-1:0] pool;
        logic found;
        pool = freeVec;
        enough = 1'b1;
        for (int i = 0; i < WIDTH; i++) begin
            allocTags[i] = '0;
            found = 1'b0;
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (allocReq[i] && !found && pool[t]) begin
                    allocTags[i] = Tag'(t);
                    pool[t] = 1'b0;
                    found = 1'b1;
                end
            end
            if (allocReq[i] && !found)
                enough = 1'b0;
        end
    end

    // Committed ownership, set before release so a tag
    // overwritten within one commit group ends up free
    always_comb begin
        comOwnedNext = comOwned;
        for (int i = 0; i < WIDTH; i++) begin
            if (comUop[i].valid && comUop[i].rd != '0)
                comOwnedNext[comUop[i].tagDst] = 1'b1;
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (freeValid[i])
                comOwnedNext[freeTags[i]] = 1'b0;
        end
    end

    always_comb begin
        freeNext = freeVec;
        if (allocTake) begin
            for (int i = 0; i < WIDTH; i++) begin
                if (allocReq[i])
                    freeNext[allocTags[i]] = 1'b0;
            end
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (freeValid[i])
                freeNext[freeTags[i]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Low tags back the identity mapping
            for (int t = 0; t < NUM_TAGS; t++) begin
                freeVec[t] <= (t >= NUM_ARCH);
                comOwned[t] <= (t < NUM_ARCH);
            end
        end else begin
            comOwned <= comOwnedNext;
            freeVec <= flush ? ~comOwnedNext : freeNext;
        end
    end

endmodule

`default_nettype wire

//--- design/renameStage.sv
`default_nettype none
`timescale 1ns/10ps

module renameStage import renamePkg::*; #(
    parameter int WIDTH = 2
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 en,
    input  wire                 flush,
    input  wire SqN             flushSqN,
    input  wire DecUop          decUop [WIDTH],
    output ArchReg              lookupIds [2*WIDTH],
    input  wire Tag             lookupTags [2*WIDTH],
    input  wire [2*WIDTH-1:0]   lookupAvail,
    output logic [WIDTH-1:0]    issueValid,
    output ArchReg              issueIds [WIDTH],
    output Tag                  issueTags [WIDTH],
    output logic [WIDTH-1:0]    allocReq,
    input  wire Tag             allocTags [WIDTH],
    input  wire                 enough,
    output logic                allocTake,
    output logic                stall,
    output RenUop               renUop [WIDTH],
    output SqN                  nextSqN
);

    SqN                 counterSqN;
    SqN                 bundleEndSqN;
    SqN                 opSqN [WIDTH];
    logic               accept;
    Tag                 srcTag [2*WIDTH];
    logic [2*WIDTH-1:0] srcAvail;

    assign stall = !enough;
    assign accept = en && !stall && !flush;
    assign allocTake = accept;
    assign nextSqN = counterSqN;

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            lookupIds[2*i] = decUop[i].rs0;
            lookupIds[2*i+1] = decUop[i].rs1;
            allocReq[i] = decUop[i].valid && decUop[i].rd != '0;
            issueValid[i] = accept && allocReq[i];
            issueIds[i] = decUop[i].rd;
            issueTags[i] = allocTags[i];
        end
    end

    // Sources of op i may hit destinations of ops before it
    always_comb begin
        for (int s = 0; s < 2*WIDTH; s++) begin
            srcTag[s] = lookupTags[s];
            srcAvail[s] = lookupAvail[s];
            for (int j = 0; j < s / 2; j++) begin
                if (allocReq[j] && decUop[j].rd == lookupIds[s]) begin
                    srcTag[s] = allocTags[j];
                    srcAvail[s] = 1'b0;
                end
            end
        end
    end

    // Consecutive numbers over the valid ops only
    always_comb begin
        bundleEndSqN = counterSqN;
        for (int i = 0; i < WIDTH; i++) begin
            opSqN[i] = bundleEndSqN;
            if (decUop[i].valid)
                bundleEndSqN = bundleEndSqN + SqN'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counterSqN <= '0;
            for (int i = 0; i < WIDTH; i++)
                renUop[i].valid <= 1'b0;
        end else if (flush) begin
            // Restart right after the branch
            counterSqN <= flushSqN + SqN'(1);
            for (int i = 0; i < WIDTH; i++)
                renUop[i].valid <= 1'b0;
        end else if (accept) begin
            counterSqN <= bundleEndSqN;
            for (int i = 0; i < WIDTH; i++) begin
                renUop[i].valid <= decUop[i].valid;
                renUop[i].sqN <= opSqN[i];
                renUop[i].tagA <= srcTag[2*i];
                renUop[i].tagB <= srcTag[2*i+1];
                renUop[i].availA <= srcAvail[2*i];
                renUop[i].availB <= srcAvail[2*i+1];
                renUop[i].tagDst <= allocTags[i];
                renUop[i].hasDst <= allocReq[i];
                renUop[i].rd <= decUop[i].rd;
                renUop[i].imm <= decUop[i].imm;
            end
        end else begin
            // Never hold a bundle, the payload just stays put
            for (int i = 0; i < WIDTH; i++)
                renUop[i].valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/renameTop.sv
`default_nettype none
`timescale 1ns/10ps

module renameTop import renamePkg::*; #(
    parameter int WIDTH = 2
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           en,
    input  wire DecUop    decUop [WIDTH],
    input  wire ComUop    comUop [WIDTH],
    input  wire WbResult  wbRes [WIDTH],
    input  wire           flush,
    input  wire SqN       flushSqN,
    output logic          stall,
    output RenUop         renUop [WIDTH],
    output SqN            nextSqN
);

    ArchReg             lookupIds [2*WIDTH];
    Tag                 lookupTags [2*WIDTH];
    logic [2*WIDTH-1:0] lookupAvail;
    logic [WIDTH-1:0]   issueValid;
    ArchReg             issueIds [WIDTH];
    Tag                 issueTags [WIDTH];
    logic [WIDTH-1:0]   allocReq;
    Tag                 allocTags [WIDTH];
    logic               enough;
    logic               allocTake;
    Tag                 commitPrevTags [WIDTH];
    logic [WIDTH-1:0]   commitPrevValid;

    renameTable #(.WIDTH(WIDTH)) table_i (
        .clk(clk), .rst(rst), .flush(flush),
        .lookupIds(lookupIds), .lookupTags(lookupTags), .lookupAvail(lookupAvail),
        .issueValid(issueValid), .issueIds(issueIds), .issueTags(issueTags),
        .comUop(comUop), .commitPrevTags(commitPrevTags),
        .commitPrevValid(commitPrevValid), .wbRes(wbRes)
    );

    // Tags retired by commits go straight back to the pool
    tagFreeList #(.WIDTH(WIDTH)) freeList_i (
        .clk(clk), .rst(rst), .flush(flush),
        .allocReq(allocReq), .allocTags(allocTags), .enough(enough),
        .allocTake(allocTake), .freeValid(commitPrevValid),
        .freeTags(commitPrevTags), .comUop(comUop)
    );

    renameStage #(.WIDTH(WIDTH)) stage_i (
        .clk(clk), .rst(rst), .en(en), .flush(flush), .flushSqN(flushSqN),
        .decUop(decUop), .lookupIds(lookupIds), .lookupTags(lookupTags),
        .lookupAvail(lookupAvail), .issueValid(issueValid), .issueIds(issueIds),
        .issueTags(issueTags), .allocReq(allocReq), .allocTags(allocTags),
        .enough(enough), .allocTake(allocTake), .stall(stall),
        .renUop(renUop), .nextSqN(nextSqN)
    );

endmodule

`default_nettype wire

//--- verif/renameTb.sv
`default_nettype none
`timescale 1ns/10ps

module renameTb import renamePkg::*; ();

    localparam int WIDTH = 2;
    localparam int RUN_CYCLES = 2000;
    localparam int MAX_CYCLES = 3000;

    logic    clk;
    logic    rst;
    logic    en;
    logic    flush;
    SqN      flushSqN;
    DecUop   decUop [WIDTH];
    ComUop   comUop [WIDTH];
    WbResult wbRes [WIDTH];
    logic    stall;
    RenUop   renUop [WIDTH];
    SqN      nextSqN;

    // Reference model state
    Tag                  specMap [NUM_ARCH];
    Tag                  comMap [NUM_ARCH];
    logic [NUM_TAGS-1:0] ready;
    logic [NUM_TAGS-1:0] inUse;
    SqN                  modelSqN;
    RenUop               expUop [WIDTH];
    logic                holdBundle;
    ComUop               pending [$];
    int                  seed;
    int                  cycles;

    renameTop #(.WIDTH(WIDTH)) dut_i (
        .clk(clk), .rst(rst), .en(en), .decUop(decUop), .comUop(comUop),
        .wbRes(wbRes), .flush(flush), .flushSqN(flushSqN), .stall(stall),
        .renUop(renUop), .nextSqN(nextSqN)
    );

    always #2 clk = ~clk;

    task automatic reportError(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic DecUop randomUop();
        DecUop u;
        u.valid = randBelow(4) != 0;
        u.rs0 = ArchReg'(randBelow(NUM_ARCH));
        u.rs1 = ArchReg'(randBelow(NUM_ARCH));
        u.rd = ArchReg'(randBelow(NUM_ARCH));
        u.imm = 8'(randBelow(256));
        return u;
    endfunction

    function automatic Tag lowestFree(input logic [NUM_TAGS-1:0] pool);
        for (int t = NUM_TAGS - 1; t >= 0; t--) begin
            if (pool[t])
                lowestFree = Tag'(t);
        end
    endfunction

    // Model and checks run at the falling edge when all signals are settled
    always @(negedge clk) begin
        logic [NUM_TAGS-1:0] pool;
        logic [NUM_TAGS-1:0] wbNow;
        int   req;
        int   freeCnt;
        logic accNow;
        ArchReg src;
        Tag   srcTag;
        logic srcAvail;
        SqN   seqN;
        if (rst) begin
            for (int r = 0; r < NUM_ARCH; r++) begin
                specMap[r] = Tag'(r);
                comMap[r] = Tag'(r);
            end
            for (int t = 0; t < NUM_TAGS; t++)
                inUse[t] = t < NUM_ARCH;
            ready = '1;
            modelSqN = '0;
            holdBundle = 1'b0;
            for (int i = 0; i < WIDTH; i++)
                expUop[i] = '0;
        end else begin
            // Result of the previous edge
            for (int i = 0; i < WIDTH; i++) begin
                assert (renUop[i].valid == expUop[i].valid)
                    else reportError("renUop valid bit differs from model");
                if (expUop[i].valid)
                    assert (renUop[i] == expUop[i])
                        else reportError("renamed op differs from model");
            end
            assert (nextSqN == modelSqN) else reportError("nextSqN differs from model");
            req = 0;
            for (int i = 0; i < WIDTH; i++) begin
                if (decUop[i].valid && decUop[i].rd != '0)
                    req++;
            end
            freeCnt = 0;
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (!inUse[t])
                    freeCnt++;
            end
            assert (stall == (freeCnt < req)) else reportError("stall differs from free count");
            holdBundle = freeCnt < req;
            wbNow = '0;
            for (int k = 0; k < WIDTH; k++) begin
                if (wbRes[k].valid)
                    wbNow[wbRes[k].tag] = 1'b1;
            end
            accNow = en && !flush && freeCnt >= req;
            pool = ~inUse;
            seqN = modelSqN;
            for (int i = 0; i < WIDTH; i++) begin
                expUop[i] = '0;
                if (accNow) begin
                    expUop[i].valid = decUop[i].valid;
                    expUop[i].rd = decUop[i].rd;
                    expUop[i].imm = decUop[i].imm;
                    expUop[i].sqN = seqN;
                    if (decUop[i].valid)
                        seqN = seqN + SqN'(1);
                    expUop[i].hasDst = decUop[i].valid && decUop[i].rd != '0;
                    if (expUop[i].hasDst) begin
                        expUop[i].tagDst = lowestFree(pool);
                        pool[expUop[i].tagDst] = 1'b0;
                    end
                    for (int s = 0; s < 2; s++) begin
                        src = (s == 0) ? decUop[i].rs0 : decUop[i].rs1;
                        srcTag = specMap[src];
                        srcAvail = ready[srcTag] || wbNow[srcTag];
                        // Earlier ops in the bundle override the map
                        for (int j = 0; j < i; j++) begin
                            if (expUop[j].hasDst && expUop[j].rd == src) begin
                                srcTag = expUop[j].tagDst;
                                srcAvail = 1'b0;
                            end
                        end
                        if (s == 0) begin
                            expUop[i].tagA = srcTag;
                            expUop[i].availA = srcAvail;
                        end else begin
                            expUop[i].tagB = srcTag;
                            expUop[i].availB = srcAvail;
                        end
                    end
                end
            end
            // State after the coming edge
            ready = ready | wbNow;
            for (int i = 0; i < WIDTH; i++) begin
                if (expUop[i].valid)
                    pending.push_back({1'b1, expUop[i].rd, expUop[i].tagDst, expUop[i].sqN});
                if (expUop[i].hasDst) begin
                    specMap[expUop[i].rd] = expUop[i].tagDst;
                    ready[expUop[i].tagDst] = 1'b0;
                    inUse[expUop[i].tagDst] = 1'b1;
                end
            end
            modelSqN = seqN;
            for (int k = 0; k < WIDTH; k++) begin
                if (comUop[k].valid && comUop[k].rd != '0) begin
                    inUse[comMap[comUop[k].rd]] = 1'b0;
                    comMap[comUop[k].rd] = comUop[k].tagDst;
                end
            end
            if (flush) begin
                specMap = comMap;
                ready = '1;
                inUse = '0;
                for (int r = 0; r < NUM_ARCH; r++)
                    inUse[comMap[r]] = 1'b1;
                modelSqN = flushSqN + SqN'(1);
            end
        end
    end

    // Stimulus holds the bundle while stalled
    always @(posedge clk) begin
        int    nCom;
        ComUop c;
        if (!rst) begin
            flush <= 1'b0;
            en <= randBelow(10) != 0;
            if (!holdBundle) begin
                for (int i = 0; i < WIDTH; i++)
                    decUop[i] <= randomUop();
            end
            for (int k = 0; k < WIDTH; k++) begin
                wbRes[k] <= '0;
                if (pending.size() > 0 && randBelow(2) == 0) begin
                    c = pending[randBelow(pending.size())];
                    wbRes[k] <= {c.rd != '0, c.tagDst};
                end
            end
            nCom = randBelow(3);
            for (int k = 0; k < WIDTH; k++) begin
                comUop[k] <= '0;
                if (k < nCom && pending.size() > 0) begin
                    c = pending.pop_front();
                    comUop[k] <= c;
                    // Mispredict on the last committed op squashes the rest
                    if (k == nCom - 1 && randBelow(30) == 0) begin
                        flush <= 1'b1;
                        flushSqN <= c.sqN;
                        pending.delete();
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed = 32'hcf17efcc;
        cycles = 0;
        clk = 1'b0;
        rst = 1'b1;
        en = 1'b0;
        flush = 1'b0;
        flushSqN = '0;
        for (int i = 0; i < WIDTH; i++) begin
            decUop[i] = '0;
            comUop[i] = '0;
            wbRes[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (RUN_CYCLES) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/renamePkg.sv
design/renameTable.sv
design/tagFreeList.sv
design/renameStage.sv
design/renameTop.sv
verif/renameTb.sv

//--- run.sh
#!/bin/sh
# Build and run the rename stage testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal -f build.f --top-module renameTb -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
